//--- laneCore.f
+incdir+rtl
rtl/laneUopPkg.sv
rtl/laneDataPkg.sv
rtl/laneDecode.sv
rtl/laneExecute1.sv
rtl/laneExecute2.sv
rtl/laneResult.sv
rtl/laneCore.sv
verification/laneCore_asserts.sv
verification/laneCoreTb.sv

//--- verification/laneCore_input.txt
# Records: T name opens a test, I word sends one instruction (hex),
# E reg value expects one result record (hex), in retire order within its test
T alu
I 07100123 E 1 00000123  I 07200FFB E 2 FFFFFFFB
I 073007FF E 3 000007FF  I 01412000 E 4 0000011E
I 02513000 E 5 FFFFF924  I 03623000 E 6 000007FB
I 04713000 E 7 000007FF  I 05845000 E 8 FFFFF83A
I 06910F00 E 9 00000023
T bypass
I 07A00010 E A 00000010  I 00000000
I 06AA0005 E A 00000015  I 00000000
I 01BAA000 E B 0000002A  I 00000000  I 00000000
I 02CBA000 E C 00000015
I 07D00111 E D 00000111  I 07D00222 E D 00000222
I 00000000  I 01ED0000 E E 00000222
T predicate
I 47100055  I 87200066  I C7300077 E 3 00000077
I 080AC000  I 87400044 E 4 00000044  I C75000AA
I 09021000  I 81600000  I 48000000
I C77007AB E 7 000007AB  I 09012000  I 86810001 E 8 00000124
I 3F900000  I 07900099 E 9 00000099
T memory
I 0C0A5003  I 0BF00018 E F FFFFF924
I 0C00D0FF  I 0C0070FE  I 0B1000FF E 1 00000222  I 0B2000FE E 2 000007AB
I 0A355000 E 3 002F0D10  I 0A4D8000 E 4 00026EC8  I 0A65D000 E 6 FFF15EC8
T backpressure
I 07100001 E 1 00000001  I 07200002 E 2 00000002
I 07300003 E 3 00000003  I 07400004 E 4 00000004
I 01513000 E 5 00000004  I 01624000 E 6 00000006
I 05751000 E 7 00000005  I 02865000 E 8 00000002
I 0BB00018 E B FFFFF924  I 00000000  I 01CB7000 E C FFFFF929

//--- verification/laneCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "laneCfg_cfg.svh"

module laneCoreTb;
	import laneUopPkg::*;
	import laneDataPkg::*;

	logic clock;
	logic arstN;
	logic instrValid;
	instrT instrWord;
	logic instrCredit;
	logic resultValid;
	resultT result;
	logic resultCredit;

	string kinds[$];		// Record tag per file record
	string names[$];
	logic [31:0] argA[$];
	logic [31:0] argB[$];
	resultT expQ[$];		// Expected records, retire order
	resultT expRec;
	resultT pending;
	int creditDue[$];		// Cycle at which each owed credit goes back
	int cycleCount = 0;
	int srcCredits = `LANE_IN_DEPTH;		// Source side credit count
	int checks = 0;
	int errors = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	string curName = "";
	bit runAborted = 1'b0;		// Timeout or unusable stimulus file

	laneCore i_laneCore (
		.clock(clock), .arstN(arstN), .instrValid(instrValid), .instrWord(instrWord),
		.instrCredit(instrCredit), .resultValid(resultValid), .result(result),
		.resultCredit(resultCredit)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic flagAbort(input string why);
		$display("error: %s", why);
		runAborted = 1'b1;
	endtask

	task automatic readStimulus();
		int fd;
		string tag;
		string line;
		string name;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("verification/laneCore_input.txt", "r");
		if (fd == 0) begin
			flagAbort("cannot open verification/laneCore_input.txt");
		end else begin
			while (!runAborted && $fscanf(fd, "%s", tag) == 1) begin
				name = "";
				a = '0;
				b = '0;
				if (tag == "#") begin
					void'($fgets(line, fd));		// Skip comment text
				end else begin
					if (tag == "T")
						void'($fscanf(fd, "%s", name));
					else if (tag == "I")
						void'($fscanf(fd, "%h", a));
					else if (tag == "E")
						void'($fscanf(fd, "%h %h", a, b));
					else
						flagAbort($sformatf("unknown record %s in stimulus file", tag));
					if (!runAborted) begin
						kinds.push_back(tag);
						names.push_back(name);
						argA.push_back(a);
						argB.push_back(b);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic sendInstr(input logic [31:0] word);
		int waited;
		waited = 0;
		while (srcCredits == 0 && !runAborted) begin		// Stall until a credit returns
			instrValid = 1'b0;
			@(posedge clock);
			#1;
			waited++;
			if (waited > 1000)
				flagAbort("timeout waiting for an input credit");
		end
		if (!runAborted) begin
			instrValid = 1'b1;
			instrWord = word;
			srcCredits--;
			@(posedge clock);
			#1;
			instrValid = 1'b0;
		end
	endtask

	task automatic finishTest();
		int waited;
		waited = 0;
		while (expQ.size() != 0 && !runAborted) begin		// Drain expected records
			@(posedge clock);
			#1;
			waited++;
			if (waited > 2000)
				flagAbort($sformatf("timeout in test %s, %0d expected records never came",
					curName, expQ.size()));
		end
		testsRun++;
		if (runAborted) begin
			testsFailed++;
			$display("test %s: failed, it did not complete", curName);
		end else if (errors == testErrors) begin
			$display("test %s: passed", curName);
		end else begin
			testsFailed++;
			$display("test %s: failed with %0d errors", curName, errors - testErrors);
		end
		curName = "";		// No test open
	endtask

	// Checker, credit counting and credit scheduling on the stable half cycle
	always @(negedge clock) begin
		if (arstN && instrCredit)
			srcCredits++;
		if (arstN && resultValid) begin
			if (expQ.size() == 0) begin
				errors++;
				$display("unexpected result record r%0d = %h at %0t", result.regId,
					result.value, $time);
			end else begin
				expRec = expQ.pop_front();
				checks++;
				if (result.regId != expRec.regId || result.value != expRec.value) begin
					errors++;
					$display("mismatch at %0t: got r%0d = %h, expected r%0d = %h", $time,
						result.regId, result.value, expRec.regId, expRec.value);
				end
			end
			creditDue.push_back(cycleCount + 1 + int'($urandom % 16));		// Long delays force hold
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		#1;
		resultCredit = 1'b0;
		if (creditDue.size() != 0 && creditDue[0] <= cycleCount) begin
			void'(creditDue.pop_front());
			resultCredit = 1'b1;		// At most one credit per cycle
		end
	end

	initial begin
		void'($urandom(32'h0425_6188));
		arstN = 1'b0;
		instrValid = 1'b0;
		instrWord = '0;
		resultCredit = 1'b0;
		readStimulus();
		repeat (10) @(posedge clock);
		#1;
		arstN = 1'b1;
		for (int i = 0; i < kinds.size() && !runAborted; i++) begin
			if (kinds[i] == "T") begin
				if (curName != "")
					finishTest();
				curName = names[i];
				testErrors = errors;
				for (int j = i + 1; j < kinds.size() && kinds[j] != "T"; j++) begin
					if (kinds[j] == "E") begin		// Queue before any record can retire
						pending.regId = argA[j][3:0];
						pending.value = argB[j];
						expQ.push_back(pending);
					end
				end
			end else if (kinds[i] == "I") begin
				sendInstr(argA[i]);
			end
		end
		if (curName != "")
			finishTest();
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			testsRun, testsFailed, checks, errors, i_laneCore.i_laneCoreAsserts.assertFails);
		if (!runAborted && checks != 0 && errors == 0 && testsFailed == 0
			&& i_laneCore.i_laneCoreAsserts.assertFails == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/laneCore_asserts.sv
`timescale 1ns/1ps
`default_nettype none
`include "laneCfg_cfg.svh"

module laneCoreAsserts (
	input logic clock,
	input logic arstN,
	input logic instrValid,
	input logic instrCredit,
	input logic resultValid,
	input logic resultCredit,
	input logic hold
);
	int inCredits;		// Credits still held by the source
	int outCredits;		// Credits still held by the core
	int assertFails = 0;		// Read by the testbench at the end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			inCredits <= `LANE_IN_DEPTH;
			outCredits <= `LANE_OUT_CREDITS;
		end else begin
			inCredits <= inCredits - int'(instrValid) + int'(instrCredit);
			outCredits <= outCredits - int'(resultValid) + int'(resultCredit);
		end
	end

	sendHasCredit: assert property (@(posedge clock) disable iff (!arstN)
		resultValid |-> outCredits > 0)
		else begin
			assertFails++;
			$error("result record sent with no output credit left");
		end

	sourceHasCredit: assert property (@(posedge clock) disable iff (!arstN)
		instrValid |-> inCredits > 0)
		else begin
			assertFails++;
			$error("instruction sent with no input credit left");
		end

	creditsBounded: assert property (@(posedge clock) disable iff (!arstN)
		inCredits <= `LANE_IN_DEPTH && outCredits <= `LANE_OUT_CREDITS)
		else begin
			assertFails++;
			$error("more credits returned than were spent");
		end

	// Control outputs quiet while reset is applied
	resetQuiet: assert property (@(posedge clock)
		!arstN |-> !resultValid && !instrCredit && !hold)
		else begin
			assertFails++;
			$error("control output high during reset");
		end

endmodule

bind laneCore laneCoreAsserts i_laneCoreAsserts (
	.clock(clock), .arstN(arstN), .instrValid(instrValid), .instrCredit(instrCredit),
	.resultValid(resultValid), .resultCredit(resultCredit), .hold(hold)
);

`default_nettype wire

//--- rtl/laneCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "laneCfg_cfg.svh"

module laneCore (
	input logic clock,
	input logic arstN,
	input logic instrValid,
	input laneUopPkg::instrT instrWord,
	output logic instrCredit,
	output logic resultValid,
	output laneDataPkg::resultT result,
	input logic resultCredit
);
	import laneUopPkg::*;
	import laneDataPkg::*;

	uopT uop;		// Decode register
	ex1OutT ex1Out;		// EX1 register
	logic [`LANE_DATA_W-1:0] ramData;
	resultT ex2Res;		// EX2 register
	logic ex2Valid;
	logic [3:0] rsId;
	logic [3:0] rtId;
	logic [`LANE_DATA_W-1:0] rsData;
	logic [`LANE_DATA_W-1:0] rtData;
	logic wbValid;
	logic [3:0] wbReg;
	logic [`LANE_DATA_W-1:0] wbValue;
	logic hold;		// Common stall from output side

	laneDecode i_laneDecode (
		.clock(clock), .arstN(arstN), .instrValid(instrValid), .instrWord(instrWord),
		.hold(hold), .instrCredit(instrCredit), .uop(uop)
	);

	laneExecute1 i_laneExecute1 (
		.clock(clock), .arstN(arstN), .hold(hold), .uop(uop),
		.rsData(rsData), .rtData(rtData),
		.wbValid(wbValid), .wbReg(wbReg), .wbValue(wbValue),
		.ex2Res(ex2Res), .ex2Valid(ex2Valid), .rsId(rsId), .rtId(rtId),
		.ex1Out(ex1Out), .ramData(ramData)
	);

	laneExecute2 i_laneExecute2 (
		.clock(clock), .arstN(arstN), .hold(hold), .ex1Out(ex1Out),
		.ramData(ramData), .ex2Res(ex2Res), .ex2Valid(ex2Valid)
	);

	laneResult i_laneResult (
		.clock(clock), .arstN(arstN), .ex2Res(ex2Res), .ex2Valid(ex2Valid),
		.rsId(rsId), .rtId(rtId), .resultCredit(resultCredit),
		.rsData(rsData), .rtData(rtData),
		.wbValid(wbValid), .wbReg(wbReg), .wbValue(wbValue),
		.result(result), .resultValid(resultValid), .hold(hold)
	);

endmodule

`default_nettype wire

//--- rtl/laneResult.sv
`timescale 1ns/1ps
`default_nettype none
`include "laneCfg_cfg.svh"

module laneResult (
	input logic clock,
	input logic arstN,
	input laneDataPkg::resultT ex2Res,
	input logic ex2Valid,
	input logic [3:0] rsId,
	input logic [3:0] rtId,
	input logic resultCredit,
	output logic [`LANE_DATA_W-1:0] rsData,
	output logic [`LANE_DATA_W-1:0] rtData,
	output logic wbValid,
	output logic [3:0] wbReg,
	output logic [`LANE_DATA_W-1:0] wbValue,
	output laneDataPkg::resultT result,
	output logic resultValid,
	output logic hold
);
	import laneDataPkg::*;

	localparam int CRED_W = $clog2(`LANE_OUT_CREDITS + 1);

	logic [`LANE_DATA_W-1:0] regFile [`LANE_REGS];
	logic [CRED_W-1:0] credits;		// Output credits in hand
	logic outFull;		// Output register holds a record
	logic send;

	assign send = outFull && (credits != '0);
	assign resultValid = send;
	assign hold = outFull && (credits == '0);		// Freezes every stage

	// Output register doubles as the register file write port
	assign wbValid = outFull;
	assign wbReg = result.regId;
	assign wbValue = result.value;

	assign rsData = regFile[rsId];		// Async reads for EX1
	assign rtData = regFile[rtId];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			credits <= CRED_W'(`LANE_OUT_CREDITS);
		else
			credits <= credits - CRED_W'(send) + CRED_W'(resultCredit);
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			outFull <= 1'b0;
			result <= '0;
		end else if (!hold) begin
			outFull <= ex2Valid;		// Pending record has just been sent
			if (ex2Valid)
				result <= ex2Res;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `LANE_REGS; i++)
				regFile[i] <= '0;
		end else if (wbValid) begin
			regFile[wbReg] <= wbValue;		// Repeats harmlessly while held
		end
	end

endmodule

`default_nettype wire

//--- rtl/laneExecute2.sv
`timescale 1ns/1ps
`default_nettype none
`include "laneCfg_cfg.svh"

module laneExecute2 (
	input logic clock,
	input logic arstN,
	input logic hold,
	input laneDataPkg::ex1OutT ex1Out,
	input logic [`LANE_DATA_W-1:0] ramData,
	output laneDataPkg::resultT ex2Res,
	output logic ex2Valid
);
	import laneUopPkg::*;
	import laneDataPkg::*;

	resultT resNext;
	logic writesReg;		// Opcode has a destination
	logic [`LANE_DATA_W-1:0] mulSum;

	// Product modulo 2^32 from the partials
	assign mulSum = ex1Out.mulLo + (ex1Out.mulCross << HALF_W);

	always_comb begin
		resNext.regId = ex1Out.rd;
		resNext.value = ex1Out.value;		// Forward EX1 value by default
		writesReg = 1'b0;
		case (ex1Out.opcode)
			ADD, SUB, AND, OR, XOR, ADDI, MOVI: begin
				writesReg = 1'b1;
			end
			LOAD: begin
				resNext.value = ramData;		// RAM word arrived this cycle
				writesReg = 1'b1;
			end
			MUL: begin
				resNext.value = mulSum;
				writesReg = 1'b1;
			end
			default: begin
				writesReg = 1'b0;		// Compares, stores and NOP
			end
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			ex2Res <= '0;
			ex2Valid <= 1'b0;
		end else if (!hold) begin
			ex2Res <= resNext;		// Also first bypass source
			ex2Valid <= ex1Out.valid && ex1Out.enable && writesReg;
		end
	end

endmodule

`default_nettype wire

//--- rtl/laneExecute1.sv
`timescale 1ns/1ps
`default_nettype none
`include "laneCfg_cfg.svh"

module laneExecute1 (
	input logic clock,
	input logic arstN,
	input logic hold,
	input laneUopPkg::uopT uop,
	input logic [`LANE_DATA_W-1:0] rsData,
	input logic [`LANE_DATA_W-1:0] rtData,
	input logic wbValid,
	input logic [3:0] wbReg,
	input logic [`LANE_DATA_W-1:0] wbValue,
	input laneDataPkg::resultT ex2Res,
	input logic ex2Valid,
	output logic [3:0] rsId,
	output logic [3:0] rtId,
	output laneDataPkg::ex1OutT ex1Out,
	output logic [`LANE_DATA_W-1:0] ramData
);
	import laneUopPkg::*;
	import laneDataPkg::*;

	localparam int RAM_AW = $clog2(`LANE_RAM_WORDS);

	logic [`LANE_DATA_W-1:0] dataRam [`LANE_RAM_WORDS];		// Local data RAM
	logic tFlag;		// Compare result steering predicates
	logic [`LANE_DATA_W-1:0] opA;
	logic [`LANE_DATA_W-1:0] opB;
	logic predOk;
	logic enable;
	logic [`LANE_DATA_W-1:0] aluRes;
	logic cmpRes;
	logic [RAM_AW-1:0] ramAddr;
	ex1OutT ex1Next;

	assign rsId = uop.rs;		// Register file read ports
	assign rtId = uop.rt;

	// EX2 register first, then the write port, then the file
	assign opA = (ex2Valid && ex2Res.regId == uop.rs) ? ex2Res.value :
		(wbValid && wbReg == uop.rs) ? wbValue : rsData;
	assign opB = (ex2Valid && ex2Res.regId == uop.rt) ? ex2Res.value :
		(wbValid && wbReg == uop.rt) ? wbValue : rtData;

	always_comb begin
		case (uop.pred)
			ALWAYS: predOk = 1'b1;
			NEVER: predOk = 1'b0;
			IFT: predOk = tFlag;
			IFNOTT: predOk = !tFlag;
			default: predOk = 1'b0;
		endcase
	end

	assign enable = uop.valid && predOk;

	always_comb begin
		aluRes = '0;
		cmpRes = 1'b0;
		case (uop.opcode)
			ADD: aluRes = opA + opB;
			SUB: aluRes = opA - opB;
			AND: aluRes = opA & opB;
			OR: aluRes = opA | opB;
			XOR: aluRes = opA ^ opB;
			ADDI, LOAD, STORE: aluRes = opA + uop.imm;		// Sum or word address
			MOVI: aluRes = uop.imm;
			CMPEQ: cmpRes = (opA == opB);
			CMPGT: cmpRes = ($signed(opA) > $signed(opB));
			default: aluRes = '0;		// MUL finishes in EX2
		endcase
	end

	assign ramAddr = aluRes[RAM_AW-1:0];

	always_comb begin
		ex1Next.valid = uop.valid;
		ex1Next.enable = enable;
		ex1Next.opcode = uop.opcode;
		ex1Next.rd = uop.rd;
		ex1Next.value = aluRes;
		ex1Next.mulLo = opA[HALF_W-1:0] * opB[HALF_W-1:0];
		ex1Next.mulCross = opA[`LANE_DATA_W-1:HALF_W] * opB[HALF_W-1:0]
			+ opA[HALF_W-1:0] * opB[`LANE_DATA_W-1:HALF_W];		// Only low half survives the shift
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			ex1Out <= '0;
			tFlag <= 1'b0;
		end else if (!hold) begin
			ex1Out <= ex1Next;
			if (enable && (uop.opcode == CMPEQ || uop.opcode == CMPGT))
				tFlag <= cmpRes;		// Seen by the next micro-op
		end
	end

	always_ff @(posedge clock) begin
		if (!hold && enable) begin
			if (uop.opcode == STORE)
				dataRam[ramAddr] <= opB;
			if (uop.opcode == LOAD)
				ramData <= dataRam[ramAddr];		// Lines up with ex1Out in EX2
		end
	end

endmodule

`default_nettype wire

//--- rtl/laneDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "laneCfg_cfg.svh"

module laneDecode (
	input logic clock,
	input logic arstN,
	input logic instrValid,
	input laneUopPkg::instrT instrWord,
	input logic hold,
	output logic instrCredit,
	output laneUopPkg::uopT uop
);
	import laneUopPkg::*;

	localparam int PTR_W = (`LANE_IN_DEPTH > 1) ? $clog2(`LANE_IN_DEPTH) : 1;
	localparam int CNT_W = $clog2(`LANE_IN_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(`LANE_IN_DEPTH - 1);

	instrT queueMem [`LANE_IN_DEPTH];		// Queue storage
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] fill;		// Entries waiting
	logic pop;
	instrT head;
	uopT uopNext;

	assign pop = !hold && (fill != '0);		// One entry per free cycle
	assign head = queueMem[rdPtr];

	always_comb begin
		uopNext.valid = pop;		// Bubble when queue empty
		uopNext.pred = predT'(head.pred);
		uopNext.rd = head.rd;
		uopNext.rs = head.rs;
		uopNext.rt = head.rt;
		uopNext.imm = {{(`LANE_DATA_W - IMM_W){head.imm[IMM_W-1]}}, head.imm};
		case (head.opcode)
			ADD, SUB, AND, OR, XOR, ADDI, MOVI,
			CMPEQ, CMPGT, MUL, LOAD, STORE: uopNext.opcode = opcodeT'(head.opcode);
			default: uopNext.opcode = NOP;		// Unknown codes retire silently
		endcase
	end

	always_ff @(posedge clock) begin
		if (instrValid)
			queueMem[wrPtr] <= instrWord;		// Source holds a credit
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			instrCredit <= 1'b0;
		end else begin
			if (instrValid)
				wrPtr <= (wrPtr == LAST) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == LAST) ? '0 : rdPtr + 1'b1;
			fill <= fill + CNT_W'(instrValid) - CNT_W'(pop);
			instrCredit <= pop;		// Credit goes back a cycle after pop
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			uop <= '0;
		else if (!hold)
			uop <= uopNext;		// Frozen under hold
	end

endmodule

`default_nettype wire

//--- rtl/laneDataPkg.sv
`default_nettype none
`include "laneCfg_cfg.svh"

package laneDataPkg;

	localparam int HALF_W = `LANE_DATA_W / 2;		// Multiplier operand split

	// EX1 register contents handed to EX2
	typedef struct packed {
		logic valid;		// Slot holds a micro-op
		logic enable;		// Predicate passed
		laneUopPkg::opcodeT opcode;
		logic [laneUopPkg::REG_W-1:0] rd;
		logic [`LANE_DATA_W-1:0] value;		// ALU result or address
		logic [`LANE_DATA_W-1:0] mulLo;		// Low half times low half
		logic [`LANE_DATA_W-1:0] mulCross;		// Sum of both cross products
	} ex1OutT;

	// Retired register write, EX2 onward and on the output port
	typedef struct packed {
		logic [laneUopPkg::REG_W-1:0] regId;
		logic [`LANE_DATA_W-1:0] value;
	} resultT;

endpackage

`default_nettype wire

//--- rtl/laneUopPkg.sv
`default_nettype none
`include "laneCfg_cfg.svh"

package laneUopPkg;

	localparam int PRED_W = 2;		// Predicate field
	localparam int OPC_W = 6;		// Opcode field
	localparam int REG_W = $clog2(`LANE_REGS);	// Register id field
	localparam int IMM_W = 12;		// Short immediate, sign-extended at decode

	typedef enum logic [PRED_W-1:0] {
		ALWAYS = 2'd0,		// Unconditional
		NEVER = 2'd1,		// Squashed
		IFT = 2'd2,		// Runs when T set
		IFNOTT = 2'd3		// Runs when T clear
	} predT;

	typedef enum logic [OPC_W-1:0] {
		NOP = 6'd0,
		ADD = 6'd1,
		SUB = 6'd2,
		AND = 6'd3,
		OR = 6'd4,
		XOR = 6'd5,
		ADDI = 6'd6,		// rs + imm
		MOVI = 6'd7,		// imm only
		CMPEQ = 6'd8,		// Sets T, no register write
		CMPGT = 6'd9,		// Signed compare into T
		MUL = 6'd10,		// Low 32 bits, finished in EX2
		LOAD = 6'd11,		// Word at rs + imm
		STORE = 6'd12		// rt to word at rs + imm
	} opcodeT;

	// Raw instruction word as it arrives on the input port
	typedef struct packed {
		logic [PRED_W-1:0] pred;		// Bits 31:30
		logic [OPC_W-1:0] opcode;		// Bits 29:24, unchecked
		logic [REG_W-1:0] rd;		// Bits 23:20
		logic [REG_W-1:0] rs;		// Bits 19:16
		logic [REG_W-1:0] rt;		// Bits 15:12
		logic [IMM_W-1:0] imm;		// Bits 11:0
	} instrT;

	typedef struct packed {
		logic valid;
		predT pred;
		opcodeT opcode;		// Unknown codes already mapped to NOP
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [`LANE_DATA_W-1:0] imm;		// Full width
	} uopT;

endpackage

`default_nettype wire

//--- rtl/laneCfg_cfg.svh
`ifndef LANE_CFG_SVH
`define LANE_CFG_SVH

// Datapath width of registers, ALU and data RAM
`define LANE_DATA_W 32

// Architectural register count, 4-bit ids
`define LANE_REGS 16

// Input queue entries, also the source's starting credit
`define LANE_IN_DEPTH 4

// Output records the core may send before any credit comes back
`define LANE_OUT_CREDITS 4

// Local data RAM depth in words
`define LANE_RAM_WORDS 256

`endif
